/* build.f */
rtl/decode_pkg.sv
rtl/ctrl_if.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/branch_resolver.sv
rtl/id_ex_latch.sv
rtl/decode_stage.sv
testbench/tb_decode_stage.sv

/* rtl/branch_resolver.sv */
`timescale 1ns/1ns

module branch_resolver (
    input  logic [decode_pkg::NB_DATA-1:0] instr_i,
    input  logic [decode_pkg::NB_DATA-1:0] pc_plus4_i,
    input  logic [decode_pkg::NB_DATA-1:0] rs_data_i,
    input  logic [decode_pkg::NB_DATA-1:0] rt_data_i,
    input  logic                           beq_i,
    input  logic                           bne_i,
    input  logic                           jump_i,
    input  decode_pkg::pc_src_e            pc_src_i,
    input  logic                           valid_i,
    output logic                           redirect_o,
    output logic [decode_pkg::NB_DATA-1:0] redirect_pc_o
);
    import decode_pkg::*;

    logic [NB_IMM-1:0]   imm;
    logic [NB_INDEX-1:0] index;
    logic [NB_DATA-1:0]  branch_off;
    logic                equal;
    logic                taken;

    assign imm   = instr_i[NB_IMM-1:0];
    assign index = instr_i[NB_INDEX-1:0];

    // word offset, sign extended and scaled to bytes
    assign branch_off = {{(NB_DATA-NB_IMM-2){imm[NB_IMM-1]}}, imm, 2'b00};

    assign equal = (rs_data_i == rt_data_i);
    assign taken = (beq_i && equal) || (bne_i && !equal);

    always_comb begin
        case (pc_src_i)
            PC_BRANCH: begin
                redirect_pc_o = pc_plus4_i + branch_off;
            end
            PC_JUMP: begin
                // region bits come from the delay slot pc
                redirect_pc_o = {pc_plus4_i[NB_DATA-1 -: 4], index, 2'b00};
            end
            PC_REG: begin
                redirect_pc_o = rs_data_i;  // jr, jalr
            end
            default: begin
                redirect_pc_o = pc_plus4_i;
            end
        endcase
    end

    assign redirect_o = valid_i && (taken || jump_i);

endmodule

/* rtl/control_unit.sv */
`timescale 1ns/1ns

module control_unit (
    input  logic [decode_pkg::NB_DATA-1:0] instr_i,
    input  logic                           flush_i,
    ctrl_if.src                            ctrl
);
    import decode_pkg::*;

    opcode_e opcode;
    funct_e  funct;
    ctrl_t   dec;

    assign opcode = opcode_e'(instr_i[NB_DATA-1 -: NB_OP]);
    assign funct  = funct_e'(instr_i[NB_FUNCT-1:0]);

    always_comb begin
        dec = '0;  // nop and unknown opcodes stay here
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_JR: begin
                        dec.jump   = 1'b1;
                        dec.pc_src = PC_REG;  // no write back
                    end
                    FN_JALR: begin
                        dec.jump      = 1'b1;
                        dec.pc_src    = PC_REG;
                        dec.reg_dest  = RD_RD;
                        dec.reg_write = 1'b1;
                        dec.wb_src    = WB_PC;  // return address
                    end
                    default: begin
                        dec.reg_dest  = RD_RD;
                        dec.reg_write = 1'b1;
                        dec.wb_src    = WB_ALU;
                        dec.shamt     = funct inside {FN_SLL, FN_SRL, FN_SRA};
                    end
                endcase
            end
            OP_ADDI: begin
                dec.type_i    = 1'b1;
                dec.reg_write = 1'b1;
                dec.wb_src    = WB_ALU;
            end
            OP_LW, OP_LWU, OP_LB: begin
                dec.type_i    = 1'b1;
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
                dec.wb_src    = WB_MEM;
                dec.mem_sign  = (opcode != OP_LWU);  // lwu zero extends
                dec.mem_size  = (opcode == OP_LB) ? SZ_BYTE : SZ_WORD;
            end
            OP_SB: begin
                dec.type_i    = 1'b1;
                dec.mem_write = 1'b1;
                dec.mem_size  = SZ_BYTE;
            end
            OP_SH: begin
                dec.type_i    = 1'b1;
                dec.mem_write = 1'b1;
                dec.mem_size  = SZ_HALF;
            end
            OP_SW: begin
                dec.type_i    = 1'b1;
                dec.mem_write = 1'b1;
                dec.mem_size  = SZ_WORD;
            end
            OP_BEQ: begin
                dec.type_i = 1'b1;
                dec.beq    = 1'b1;
                dec.pc_src = PC_BRANCH;
            end
            OP_BNE: begin
                dec.type_i = 1'b1;
                dec.bne    = 1'b1;
                dec.pc_src = PC_BRANCH;
            end
            OP_J: begin
                dec.jump   = 1'b1;
                dec.pc_src = PC_JUMP;
            end
            OP_JAL: begin
                dec.jump      = 1'b1;
                dec.pc_src    = PC_JUMP;
                dec.reg_dest  = RD_LINK;
                dec.reg_write = 1'b1;
                dec.wb_src    = WB_PC;
            end
            OP_HALT: begin
                dec.halt = 1'b1;
            end
            default: begin
                dec = '0;
            end
        endcase
    end

    assign ctrl.ctrl   = dec;
    assign ctrl.opcode = opcode;
    assign ctrl.valid  = ~flush_i;

endmodule

/* rtl/ctrl_if.sv */
`timescale 1ns/1ns

interface ctrl_if;
    import decode_pkg::*;

    ctrl_t   ctrl;    // decoded bundle
    opcode_e opcode;  // raw opcode, passed on to ex
    logic    valid;   // low while the stage is flushed

    // sampled as a level at each edge, no handshake
    modport src (
        output ctrl,
        output opcode,
        output valid
    );

    modport dst (
        input ctrl,
        input opcode,
        input valid
    );

endinterface

/* rtl/decode_pkg.sv */
package decode_pkg;

    localparam int NB_DATA     = 32;
    localparam int NB_REG_ADDR = 5;
    localparam int N_REGISTER  = 32;
    localparam int NB_OP       = 6;
    localparam int NB_FUNCT    = 6;
    localparam int NB_SHAMT    = 5;
    localparam int NB_IMM      = 16;
    localparam int NB_INDEX    = 26;

    localparam logic [NB_REG_ADDR-1:0] LINK_REG = 5'd31;  // jal target register

    typedef enum logic [NB_OP-1:0] {
        OP_RTYPE = 6'b000000,
        OP_ADDI  = 6'b001000,
        OP_LW    = 6'b100011,
        OP_LWU   = 6'b010011,
        OP_LB    = 6'b100000,
        OP_SB    = 6'b101000,
        OP_SH    = 6'b101001,
        OP_SW    = 6'b101011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_J     = 6'b110001,
        OP_JAL   = 6'b000011,
        OP_NOP   = 6'b111110,
        OP_HALT  = 6'b111111
    } opcode_e;

    // only the functs that change decode, the rest are plain alu ops
    typedef enum logic [NB_FUNCT-1:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001
    } funct_e;

    typedef enum logic [1:0] {PC_REG = 2'b00, PC_JUMP = 2'b01, PC_BRANCH = 2'b10} pc_src_e;
    typedef enum logic [1:0] {RD_RT = 2'b00, RD_RD = 2'b01, RD_LINK = 2'b10} reg_dest_e;
    typedef enum logic [1:0] {WB_MEM = 2'b00, WB_ALU = 2'b01, WB_PC = 2'b10} wb_src_e;

    typedef enum logic [2:0] {
        SZ_NONE = 3'b000,
        SZ_BYTE = 3'b001,
        SZ_HALF = 3'b010,
        SZ_WORD = 3'b100
    } mem_size_e;

    // all zero is the bubble
    typedef struct packed {
        logic      type_i;
        logic      shamt;
        logic      beq;
        logic      bne;
        logic      jump;
        logic      halt;
        pc_src_e   pc_src;
        reg_dest_e reg_dest;
        logic      mem_sign;
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      reg_write;
        wb_src_e   wb_src;
    } ctrl_t;

endpackage

/* rtl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic [decode_pkg::NB_DATA-1:0]     instr_i,
    input  logic [decode_pkg::NB_DATA-1:0]     pc_plus4_i,
    input  logic                               stall_i,
    input  logic                               flush_i,
    input  logic                               wb_we_i,
    input  logic [decode_pkg::NB_REG_ADDR-1:0] wb_addr_i,
    input  logic [decode_pkg::NB_DATA-1:0]     wb_data_i,
    output decode_pkg::ctrl_t                  ex_ctrl_o,
    output decode_pkg::opcode_e                ex_opcode_o,
    output logic [decode_pkg::NB_DATA-1:0]     ex_rs_data_o,
    output logic [decode_pkg::NB_DATA-1:0]     ex_rt_data_o,
    output logic [decode_pkg::NB_DATA-1:0]     ex_imm_o,
    output logic [decode_pkg::NB_SHAMT-1:0]    ex_shamt_o,
    output logic [decode_pkg::NB_REG_ADDR-1:0] ex_rt_o,
    output logic [decode_pkg::NB_REG_ADDR-1:0] ex_rd_o,
    output logic [decode_pkg::NB_REG_ADDR-1:0] ex_dest_o,
    output logic [decode_pkg::NB_DATA-1:0]     ex_pc_plus4_o,
    output logic                               redirect_o,
    output logic [decode_pkg::NB_DATA-1:0]     redirect_pc_o
);
    import decode_pkg::*;

    logic [NB_DATA-1:0] rs_data;
    logic [NB_DATA-1:0] rt_data;

    ctrl_if ctrl_bus ();

    control_unit i_control_unit (
        .instr_i (instr_i),
        .flush_i (flush_i),
        .ctrl    (ctrl_bus.src)
    );

    // rs and rt fields index the two read ports
    register_file i_register_file (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rs_addr_i (instr_i[25:21]),
        .rt_addr_i (instr_i[20:16]),
        .we_i      (wb_we_i),
        .waddr_i   (wb_addr_i),
        .wdata_i   (wb_data_i),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

    branch_resolver i_branch_resolver (
        .instr_i       (instr_i),
        .pc_plus4_i    (pc_plus4_i),
        .rs_data_i     (rs_data),
        .rt_data_i     (rt_data),
        .beq_i         (ctrl_bus.ctrl.beq),
        .bne_i         (ctrl_bus.ctrl.bne),
        .jump_i        (ctrl_bus.ctrl.jump),
        .pc_src_i      (ctrl_bus.ctrl.pc_src),
        .valid_i       (ctrl_bus.valid),  // no redirect from a flushed slot
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    id_ex_latch i_id_ex_latch (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .ctrl          (ctrl_bus.dst),
        .instr_i       (instr_i),
        .pc_plus4_i    (pc_plus4_i),
        .rs_data_i     (rs_data),
        .rt_data_i     (rt_data),
        .ex_ctrl_o     (ex_ctrl_o),
        .ex_opcode_o   (ex_opcode_o),
        .ex_rs_data_o  (ex_rs_data_o),
        .ex_rt_data_o  (ex_rt_data_o),
        .ex_imm_o      (ex_imm_o),
        .ex_shamt_o    (ex_shamt_o),
        .ex_rt_o       (ex_rt_o),
        .ex_rd_o       (ex_rd_o),
        .ex_dest_o     (ex_dest_o),
        .ex_pc_plus4_o (ex_pc_plus4_o)
    );

endmodule

/* rtl/id_ex_latch.sv */
`timescale 1ns/1ns

module id_ex_latch (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               stall_i,
    input  logic                               flush_i,
    ctrl_if.dst                                ctrl,
    input  logic [decode_pkg::NB_DATA-1:0]     instr_i,
    input  logic [decode_pkg::NB_DATA-1:0]     pc_plus4_i,
    input  logic [decode_pkg::NB_DATA-1:0]     rs_data_i,
    input  logic [decode_pkg::NB_DATA-1:0]     rt_data_i,
    output decode_pkg::ctrl_t                  ex_ctrl_o,
    output decode_pkg::opcode_e                ex_opcode_o,
    output logic [decode_pkg::NB_DATA-1:0]     ex_rs_data_o,
    output logic [decode_pkg::NB_DATA-1:0]     ex_rt_data_o,
    output logic [decode_pkg::NB_DATA-1:0]     ex_imm_o,
    output logic [decode_pkg::NB_SHAMT-1:0]    ex_shamt_o,
    output logic [decode_pkg::NB_REG_ADDR-1:0] ex_rt_o,
    output logic [decode_pkg::NB_REG_ADDR-1:0] ex_rd_o,
    output logic [decode_pkg::NB_REG_ADDR-1:0] ex_dest_o,
    output logic [decode_pkg::NB_DATA-1:0]     ex_pc_plus4_o
);
    import decode_pkg::*;

    logic [NB_REG_ADDR-1:0] rt;
    logic [NB_REG_ADDR-1:0] rd;
    logic [NB_REG_ADDR-1:0] dest;
    logic [NB_DATA-1:0]     imm_ext;

    assign rt      = instr_i[20:16];
    assign rd      = instr_i[15:11];
    assign imm_ext = {{(NB_DATA-NB_IMM){instr_i[NB_IMM-1]}}, instr_i[NB_IMM-1:0]};

    always_comb begin
        case (ctrl.ctrl.reg_dest)
            RD_RD:   dest = rd;
            RD_LINK: dest = LINK_REG;
            default: dest = rt;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin  // flush wins over stall
            ex_ctrl_o     <= '0;
            ex_opcode_o   <= OP_RTYPE;
            ex_rs_data_o  <= '0;
            ex_rt_data_o  <= '0;
            ex_imm_o      <= '0;
            ex_shamt_o    <= '0;
            ex_rt_o       <= '0;
            ex_rd_o       <= '0;
            ex_dest_o     <= '0;
            ex_pc_plus4_o <= '0;
        end else if (!stall_i) begin
            ex_ctrl_o     <= ctrl.ctrl;
            ex_opcode_o   <= ctrl.opcode;
            ex_rs_data_o  <= rs_data_i;
            ex_rt_data_o  <= rt_data_i;
            ex_imm_o      <= imm_ext;
            ex_shamt_o    <= instr_i[10:6];
            ex_rt_o       <= rt;
            ex_rd_o       <= rd;
            ex_dest_o     <= dest;
            ex_pc_plus4_o <= pc_plus4_i;
        end
    end

    // a slot marked invalid by decode must reach ex as a bubble
    a_flush_bubble: assert property (
        @(posedge clk_i) !ctrl.valid |=> (ex_ctrl_o == '0)
    );

    // a memory op is either a load or a store, never both
    a_mem_excl: assert property (
        @(posedge clk_i) disable iff (rst_i) !(ex_ctrl_o.mem_read && ex_ctrl_o.mem_write)
    );

    a_halt_no_write: assert property (
        @(posedge clk_i) disable iff (rst_i) ex_ctrl_o.halt |-> !ex_ctrl_o.reg_write
    );

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic [decode_pkg::NB_REG_ADDR-1:0] rs_addr_i,
    input  logic [decode_pkg::NB_REG_ADDR-1:0] rt_addr_i,
    input  logic                               we_i,
    input  logic [decode_pkg::NB_REG_ADDR-1:0] waddr_i,
    input  logic [decode_pkg::NB_DATA-1:0]     wdata_i,
    output logic [decode_pkg::NB_DATA-1:0]     rs_data_o,
    output logic [decode_pkg::NB_DATA-1:0]     rt_data_o
);
    import decode_pkg::*;

    logic [NB_DATA-1:0] regs [N_REGISTER];

    // one read port, write data bypassed on an address match
    function automatic logic [NB_DATA-1:0] read_port(input logic [NB_REG_ADDR-1:0] addr);
        logic [NB_DATA-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (we_i && (addr == waddr_i)) begin
            data = wdata_i;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < N_REGISTER; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin  // r0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rs_data_o = read_port(rs_addr_i);
        rt_data_o = read_port(rt_addr_i);
    end

    // write back stage must present a known address with its enable
    a_waddr_known: assert property (
        @(posedge clk_i) disable iff (rst_i) we_i |-> !$isunknown(waddr_i)
    );

endmodule

/* testbench/tb_decode_stage.sv */
`timescale 1ns/1ns

module tb_decode_stage;
    import decode_pkg::*;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [5:0]  opcode;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] imm;
        logic [4:0]  shamt;
        logic [4:0]  rt_idx;
        logic [4:0]  rd_idx;
        logic [4:0]  dest;
        logic [31:0] pc4;
    } ex_exp_t;

    logic clk, rst_i, stall_i, flush_i, wb_we_i, redirect_o;
    logic [31:0] instr_i, pc_plus4_i, wb_data_i, redirect_pc_o;
    logic [31:0] ex_rs_data_o, ex_rt_data_o, ex_imm_o, ex_pc_plus4_o;
    logic [4:0]  wb_addr_i, ex_shamt_o, ex_rt_o, ex_rd_o, ex_dest_o;
    ctrl_t       ex_ctrl_o;
    opcode_e     ex_opcode_o;

    logic [31:0] shadow [32];  // expected register file contents
    ex_exp_t     exp_now, exp_next;
    logic        exp_redirect;
    logic [31:0] exp_redirect_pc;
    logic        rst_next, next_we, done;
    logic [4:0]  next_waddr;
    logic [31:0] next_wdata;
    int          errors, err_mark, tests, failed;

    decode_stage i_dut (.clk_i(clk), .*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic ctrl_t ref_decode(input logic [31:0] instr);
        ctrl_t      c;
        logic [5:0] op;
        logic [5:0] fn;
        c  = '0;
        op = instr[31:26];
        fn = instr[5:0];
        case (op)
            OP_RTYPE: begin
                if (fn == FN_JR || fn == FN_JALR) begin
                    c.jump   = 1'b1;
                    c.pc_src = PC_REG;
                    if (fn == FN_JALR) begin
                        c.reg_dest  = RD_RD;
                        c.reg_write = 1'b1;
                        c.wb_src    = WB_PC;
                    end
                end else begin
                    c.reg_dest  = RD_RD;
                    c.reg_write = 1'b1;
                    c.wb_src    = WB_ALU;
                    c.shamt     = (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA);
                end
            end
            OP_ADDI: begin
                c.type_i    = 1'b1;
                c.reg_write = 1'b1;
                c.wb_src    = WB_ALU;
            end
            OP_LW, OP_LWU, OP_LB: begin
                c.type_i    = 1'b1;
                c.mem_read  = 1'b1;
                c.reg_write = 1'b1;
                c.wb_src    = WB_MEM;
                c.mem_sign  = (op == OP_LW || op == OP_LB);
                c.mem_size  = (op == OP_LB) ? SZ_BYTE : SZ_WORD;
            end
            OP_SB, OP_SH, OP_SW: begin
                c.type_i    = 1'b1;
                c.mem_write = 1'b1;
                c.mem_size  = (op == OP_SB) ? SZ_BYTE : (op == OP_SH) ? SZ_HALF : SZ_WORD;
            end
            OP_BEQ, OP_BNE: begin
                c.type_i = 1'b1;
                c.beq    = (op == OP_BEQ);
                c.bne    = (op == OP_BNE);
                c.pc_src = PC_BRANCH;
            end
            OP_J, OP_JAL: begin
                c.jump   = 1'b1;
                c.pc_src = PC_JUMP;
                if (op == OP_JAL) begin
                    c.reg_dest  = RD_LINK;
                    c.reg_write = 1'b1;
                    c.wb_src    = WB_PC;
                end
            end
            OP_HALT: c.halt = 1'b1;
            default: c = '0;  // nop and unknown
        endcase
        return c;
    endfunction

    // bit 32 is the redirect, the low word the target
    function automatic logic [32:0] ref_target(input logic [31:0] instr, input logic [31:0] pc4,
                                               input logic [31:0] rs_val,
                                               input logic [31:0] rt_val);
        logic [31:0] br;
        br = pc4 + {{14{instr[15]}}, instr[15:0], 2'b00};
        case (instr[31:26])
            OP_BEQ:       return {rs_val == rt_val, br};
            OP_BNE:       return {rs_val != rt_val, br};
            OP_J, OP_JAL: return {1'b1, pc4[31:28], instr[25:0], 2'b00};
            OP_RTYPE: begin
                if (instr[5:0] == FN_JR || instr[5:0] == FN_JALR) return {1'b1, rs_val};
            end
            default: ;
        endcase
        return {1'b0, 32'h0};
    endfunction

    function automatic logic [31:0] read_reg(input logic [4:0] addr);
        if (addr == 5'd0) return 32'h0;
        if (next_we && addr == next_waddr) return next_wdata;  // bypass
        return shadow[addr];
    endfunction

    function automatic bit known_opcode(input logic [5:0] op);
        opcode_e e;
        e = e.first();
        repeat (e.num()) begin
            if (op == e) return 1'b1;
            e = e.next();
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] fn);
        return {OP_RTYPE, rs, rt, rd, 5'($urandom), fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_ctrl(input string name, input ctrl_t got, input ctrl_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic set_wb(input logic [4:0] addr, input logic [31:0] data);
        next_we    = 1'b1;
        next_waddr = addr;
        next_wdata = data;
    endtask

    task automatic drive(input logic [31:0] instr, input logic stall, input logic flush);
        logic [31:0] pc4;
        logic [32:0] tgt;
        ctrl_t       c;
        @(posedge clk);
        #1;
        pc4        = $urandom & 32'hffff_fffc;
        tgt        = ref_target(instr, pc4, read_reg(instr[25:21]), read_reg(instr[20:16]));
        c          = ref_decode(instr);
        exp_now    = exp_next;  // latched at the edge just passed
        rst_i      = rst_next;
        instr_i    = instr;
        pc_plus4_i = pc4;
        stall_i    = stall;
        flush_i    = flush;
        wb_we_i    = next_we;
        wb_addr_i  = next_waddr;
        wb_data_i  = next_wdata;
        exp_redirect    = tgt[32] && !flush;
        exp_redirect_pc = tgt[31:0];
        if (rst_next || flush) begin
            exp_next = '0;
        end else if (!stall) begin
            exp_next.ctrl   = c;
            exp_next.opcode = instr[31:26];
            exp_next.rs     = read_reg(instr[25:21]);
            exp_next.rt     = read_reg(instr[20:16]);
            exp_next.imm    = {{16{instr[15]}}, instr[15:0]};
            exp_next.shamt  = instr[10:6];
            exp_next.rt_idx = instr[20:16];
            exp_next.rd_idx = instr[15:11];
            exp_next.pc4    = pc4;
            case (c.reg_dest)
                RD_RD:   exp_next.dest = instr[15:11];
                RD_LINK: exp_next.dest = 5'd31;
                default: exp_next.dest = instr[20:16];
            endcase
        end
        if (next_we && !rst_next && next_waddr != 5'd0) shadow[next_waddr] = next_wdata;
        next_we = 1'b0;
    endtask

    task automatic end_test(input string name);
        drive({OP_NOP, 26'd0}, 1'b0, 1'b0);  // let the last checks land
        drive({OP_NOP, 26'd0}, 1'b0, 1'b0);
        tests++;
        if (errors == err_mark) begin
            $display("test %s ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // compare at the falling edge, away from drive and latch times
    initial begin
        @(posedge clk);
        forever begin
            @(negedge clk);
            check_ctrl("ex_ctrl_o", ex_ctrl_o, exp_now.ctrl);
            check_word("ex_opcode_o", ex_opcode_o, exp_now.opcode);
            check_word("ex_rs_data_o", ex_rs_data_o, exp_now.rs);
            check_word("ex_rt_data_o", ex_rt_data_o, exp_now.rt);
            check_word("ex_imm_o", ex_imm_o, exp_now.imm);
            check_word("ex_shamt_o", ex_shamt_o, exp_now.shamt);
            check_word("ex_rt_o", ex_rt_o, exp_now.rt_idx);
            check_word("ex_rd_o", ex_rd_o, exp_now.rd_idx);
            check_word("ex_dest_o", ex_dest_o, exp_now.dest);
            check_word("ex_pc_plus4_o", ex_pc_plus4_o, exp_now.pc4);
            check_bit("redirect_o", redirect_o, exp_redirect);
            if (exp_redirect) check_word("redirect_pc_o", redirect_pc_o, exp_redirect_pc);
        end
    end

    initial begin
        for (int i = 0; i < 5000 && !done; i++) @(posedge clk);
        if (!done) begin
            $display("timeout: stimulus did not complete within 5000 cycles");
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        opcode_e     op;
        funct_e      fn;
        logic [5:0]  uop;
        logic [31:0] a;
        void'($urandom(83));
        {rst_i, rst_next, stall_i, flush_i, wb_we_i, next_we, done} = 7'b1100000;
        {instr_i, pc_plus4_i, wb_addr_i, wb_data_i, next_waddr, next_wdata} = '0;
        {exp_now, exp_next, exp_redirect, exp_redirect_pc} = '0;
        {errors, err_mark, tests, failed} = '0;
        for (int i = 0; i < 32; i++) shadow[i] = 32'h0;

        repeat (3) drive({OP_NOP, 26'd0}, 1'b0, 1'b0);  // 4 reset edges with the first
        rst_next = 1'b0;
        end_test("reset");

        op = op.first();
        repeat (op.num()) begin
            drive(i_word(op, $urandom, $urandom, $urandom), 1'b0, 1'b0);
            op = op.next();
        end
        fn = fn.first();
        repeat (fn.num()) begin
            drive(r_word($urandom, $urandom, $urandom, fn), 1'b0, 1'b0);
            fn = fn.next();
        end
        drive(r_word($urandom, $urandom, $urandom, 6'h20), 1'b0, 1'b0);  // add
        repeat (8) begin
            do uop = $urandom; while (known_opcode(uop));
            drive(i_word(uop, $urandom, $urandom, $urandom), 1'b0, 1'b0);
        end
        end_test("decode");

        for (int i = 1; i < 32; i++) begin
            set_wb(i, $urandom);
            drive({OP_NOP, 26'd0}, 1'b0, 1'b0);
        end
        for (int i = 0; i < 32; i++) drive(r_word(i, 31 - i, 1, 6'h20), 1'b0, 1'b0);
        set_wb(0, $urandom);
        drive(r_word(0, 0, 2, 6'h20), 1'b0, 1'b0);  // r0 stays zero
        set_wb(5, $urandom);
        drive(r_word(5, 6, 2, 6'h20), 1'b0, 1'b0);  // same cycle bypass
        end_test("regfile");

        a = $urandom;
        set_wb(1, a);
        drive({OP_NOP, 26'd0}, 1'b0, 1'b0);
        set_wb(2, a);
        drive({OP_NOP, 26'd0}, 1'b0, 1'b0);
        set_wb(3, a + 1);
        drive({OP_NOP, 26'd0}, 1'b0, 1'b0);
        drive(i_word(OP_BEQ, 1, 2, $urandom), 1'b0, 1'b0);
        drive(i_word(OP_BEQ, 1, 3, $urandom), 1'b0, 1'b0);
        drive(i_word(OP_BNE, 1, 2, $urandom), 1'b0, 1'b0);
        drive(i_word(OP_BNE, 1, 3, 16'hfff0), 1'b0, 1'b0);  // backward
        end_test("branch");

        drive({OP_J, 26'($urandom)}, 1'b0, 1'b0);
        drive({OP_JAL, 26'($urandom)}, 1'b0, 1'b0);
        drive(r_word(3, 0, 0, FN_JR), 1'b0, 1'b0);
        drive(r_word(3, 0, $urandom, FN_JALR), 1'b0, 1'b0);
        end_test("jump");

        drive(i_word(OP_ADDI, 1, 4, $urandom), 1'b0, 1'b0);
        repeat (3) drive(i_word(OP_LW, $urandom, $urandom, $urandom), 1'b1, 1'b0);
        drive(i_word(OP_BEQ, 1, 2, $urandom), 1'b1, 1'b1);  // taken but flushed
        drive(i_word(OP_SW, 2, 3, $urandom), 1'b0, 1'b1);
        end_test("stall_flush");

        done = 1'b1;
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
